//--- hdl/fc_pkg.sv
package fc_pkg;

    ////////////////////
    // Layer geometry
    localparam int FC_NUM_CLASSES   = 10;
    localparam int FC_WORDS_PER_ROW = 4;
    localparam int FC_LANES         = 8;
    localparam int FC_PIX_W         = 8;
    localparam int FC_WGT_W         = 4;
    localparam int FC_ACC_W         = 21;

    // Derived widths
    localparam int FC_FM_DW      = FC_LANES * FC_PIX_W;
    localparam int FC_W_DW       = FC_LANES * FC_WGT_W;
    localparam int FC_PROD_W     = FC_PIX_W + FC_WGT_W;
    localparam int FC_TREE_W     = FC_PROD_W + $clog2(FC_LANES);
    localparam int FC_WORD_CNT_W = $clog2(FC_WORDS_PER_ROW);
    localparam int FC_CLS_CNT_W  = $clog2(FC_NUM_CLASSES);

    ////////////////////
    // External memory and result widths
    localparam int FC_FM_ADDR_W = 16;
    localparam int FC_W_ADDR_W  = 16;
    localparam int FC_FM_BASE_W = 9;
    localparam int FC_W_BASE_W  = 13;
    localparam int FC_CLS_W     = 5;

    ////////////////////
    // APB register map
    localparam int FC_APB_AW = 8;
    localparam int FC_APB_DW = 32;

    localparam logic [FC_APB_AW-1:0] REG_CTRL      = 8'h00;
    localparam logic [FC_APB_AW-1:0] REG_FM_BASE   = 8'h04;
    localparam logic [FC_APB_AW-1:0] REG_W_BASE    = 8'h08;
    localparam logic [FC_APB_AW-1:0] REG_STATUS    = 8'h0C;
    localparam logic [FC_APB_AW-1:0] REG_RES_CLASS = 8'h10;
    localparam logic [FC_APB_AW-1:0] REG_RES_SCORE = 8'h14;

endpackage

//--- hdl/fc_apb_regs.sv
`timescale 1ns/1ps

module fc_apb_regs import fc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // APB slave
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [FC_APB_AW-1:0]    i_paddr,
    input  logic [FC_APB_DW-1:0]    i_pwdata,
    output logic [FC_APB_DW-1:0]    o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    // Core status and results
    input  logic                    i_busy,
    input  logic                    i_res_done,
    input  logic [FC_CLS_W-1:0]     i_res_class,
    input  logic [FC_ACC_W-1:0]     i_res_score,
    // Core control
    output logic                    o_start,
    output logic [FC_FM_BASE_W-1:0] o_fm_base,
    output logic [FC_W_BASE_W-1:0]  o_w_base
);

    logic                    access;
    logic                    wr_en;
    logic                    addr_hit;
    logic                    start_q;
    logic                    done_q;
    logic [FC_FM_BASE_W-1:0] fm_base_q;
    logic [FC_W_BASE_W-1:0]  w_base_q;

    // Access phase of a transfer, never stalled
    assign access   = i_psel & i_penable;
    assign wr_en    = access & i_pwrite;
    assign o_pready = 1'b1;

    ////////////////////
    // Read mux and address decode
    always_comb begin
        addr_hit = 1'b1;
        o_prdata = '0;
        case (i_paddr)
            REG_CTRL:      o_prdata = '0;
            REG_FM_BASE:   o_prdata = FC_APB_DW'(fm_base_q);
            REG_W_BASE:    o_prdata = FC_APB_DW'(w_base_q);
            REG_STATUS:    o_prdata = {{(FC_APB_DW-2){1'b0}}, done_q, i_busy};
            REG_RES_CLASS: o_prdata = FC_APB_DW'(i_res_class);
            REG_RES_SCORE: begin
                o_prdata = {{(FC_APB_DW-FC_ACC_W){i_res_score[FC_ACC_W-1]}}, i_res_score};
            end
            default:       addr_hit = 1'b0;
        endcase
    end

    assign o_pslverr = access & ~addr_hit;

    ////////////////////
    // Writable registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_base_q <= '0;
            w_base_q  <= '0;
            start_q   <= 1'b0;
        end else begin
            // Start only from idle, one cycle wide
            start_q <= wr_en && (i_paddr == REG_CTRL) && i_pwdata[0] && !i_busy;
            if (wr_en && (i_paddr == REG_FM_BASE)) begin
                fm_base_q <= i_pwdata[FC_FM_BASE_W-1:0];
            end
            if (wr_en && (i_paddr == REG_W_BASE)) begin
                w_base_q <= i_pwdata[FC_W_BASE_W-1:0];
            end
        end
    end

    // Sticky done, cleared when the next run starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (start_q) begin
            done_q <= 1'b0;
        end else if (i_res_done) begin
            done_q <= 1'b1;
        end
    end

    assign o_start   = start_q;
    assign o_fm_base = fm_base_q;
    assign o_w_base  = w_base_q;

endmodule

//--- hdl/fc_addr_gen.sv
`timescale 1ns/1ps

module fc_addr_gen import fc_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_start,
    input  logic [FC_FM_BASE_W-1:0]  i_fm_base,
    input  logic [FC_W_BASE_W-1:0]   i_w_base,
    output logic                     o_busy,
    output logic [FC_FM_ADDR_W-1:0]  o_fm_addr,
    output logic [FC_W_ADDR_W-1:0]   o_w_addr,
    output logic                     o_issue_valid,
    output logic                     o_row_first,
    output logic                     o_row_last,
    output logic [FC_CLS_CNT_W-1:0]  o_issue_class
);

    logic                     busy_q;
    logic [FC_WORD_CNT_W-1:0] word_cnt;
    logic [FC_CLS_CNT_W-1:0]  class_cnt;
    logic [FC_FM_ADDR_W-1:0]  fm_base_q;
    logic [FC_W_ADDR_W-1:0]   row_addr;
    logic                     last_word;
    logic                     last_class;

    assign last_word  = (word_cnt == FC_WORD_CNT_W'(FC_WORDS_PER_ROW - 1));
    assign last_class = (class_cnt == FC_CLS_CNT_W'(FC_NUM_CLASSES - 1));

    ////////////////////
    // Word and class counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            word_cnt  <= '0;
            class_cnt <= '0;
        end else if (i_start) begin
            busy_q    <= 1'b1;
            word_cnt  <= '0;
            class_cnt <= '0;
        end else if (busy_q) begin
            if (last_word) begin
                word_cnt  <= '0;
                class_cnt <= class_cnt + 1'b1;
                // Final word of the final class
                if (last_class) begin
                    busy_q <= 1'b0;
                end
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // Base latches; weight row start steps by one row per class
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_base_q <= '0;
            row_addr  <= '0;
        end else if (i_start) begin
            fm_base_q <= FC_FM_ADDR_W'(i_fm_base);
            row_addr  <= FC_W_ADDR_W'(i_w_base);
        end else if (busy_q && last_word) begin
            row_addr <= row_addr + FC_W_ADDR_W'(FC_WORDS_PER_ROW);
        end
    end

    assign o_fm_addr = fm_base_q + FC_FM_ADDR_W'(word_cnt);
    assign o_w_addr  = row_addr + FC_W_ADDR_W'(word_cnt);

    // Position tags for the datapath
    assign o_busy        = busy_q;
    assign o_issue_valid = busy_q;
    assign o_row_first   = busy_q & (word_cnt == '0);
    assign o_row_last    = busy_q & last_word;
    assign o_issue_class = class_cnt;

endmodule

//--- hdl/fc_mac8.sv
`timescale 1ns/1ps

module fc_mac8 import fc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [FC_FM_DW-1:0]        i_fm_data,
    input  logic [FC_W_DW-1:0]         i_w_data,
    input  logic                       i_issue_valid,
    input  logic                       i_row_first,
    input  logic                       i_row_last,
    input  logic [FC_CLS_CNT_W-1:0]    i_issue_class,
    output logic                       o_sum_valid,
    output logic signed [FC_ACC_W-1:0] o_sum_value,
    output logic [FC_CLS_CNT_W-1:0]    o_sum_class
);

    // Tags: d1 meets memory data, d2 the products, d3 the tree sum
    logic                        valid_d1, valid_d2, valid_d3;
    logic                        first_d1, first_d2, first_d3;
    logic                        last_d1, last_d2, last_d3;
    logic [FC_CLS_CNT_W-1:0]     class_d1, class_d2, class_d3;

    logic signed [FC_PIX_W-1:0]  pix [FC_LANES];
    logic signed [FC_WGT_W-1:0]  wgt [FC_LANES];
    logic signed [FC_PROD_W-1:0] prod_q [FC_LANES];
    logic signed [FC_PROD_W:0]   lvl1 [FC_LANES/2];
    logic signed [FC_PROD_W+1:0] lvl2 [FC_LANES/4];
    logic signed [FC_TREE_W-1:0] tree_sum;
    logic signed [FC_TREE_W-1:0] tree_q;
    logic signed [FC_ACC_W-1:0]  acc_q;
    logic                        sum_valid_q;
    logic [FC_CLS_CNT_W-1:0]     sum_class_q;

    ////////////////////
    // Lane split, lane 0 in the low bits
    always_comb begin
        for (int i = 0; i < FC_LANES; i++) begin
            pix[i] = i_fm_data[i*FC_PIX_W +: FC_PIX_W];
            wgt[i] = i_w_data[i*FC_WGT_W +: FC_WGT_W];
        end
    end

    // Pairwise adder tree over the registered products
    always_comb begin
        for (int i = 0; i < FC_LANES/2; i++) begin
            lvl1[i] = prod_q[2*i] + prod_q[2*i+1];
        end
        for (int i = 0; i < FC_LANES/4; i++) begin
            lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
        end
        tree_sum = lvl2[0] + lvl2[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d1    <= 1'b0;
            valid_d2    <= 1'b0;
            valid_d3    <= 1'b0;
            sum_valid_q <= 1'b0;
        end else begin
            valid_d1    <= i_issue_valid;
            valid_d2    <= valid_d1;
            valid_d3    <= valid_d2;
            sum_valid_q <= valid_d3 & last_d3;
        end
    end

    ////////////////////
    // Data pipeline with tags alongside
    always_ff @(posedge clk) begin
        {first_d1, last_d1, class_d1} <= {i_row_first, i_row_last, i_issue_class};
        {first_d2, last_d2, class_d2} <= {first_d1, last_d1, class_d1};
        {first_d3, last_d3, class_d3} <= {first_d2, last_d2, class_d2};
        for (int i = 0; i < FC_LANES; i++) begin
            prod_q[i] <= pix[i] * wgt[i];
        end
        tree_q <= tree_sum;
        // Row accumulator restarts on the first word
        if (valid_d3) begin
            acc_q <= first_d3 ? FC_ACC_W'(tree_q) : acc_q + tree_q;
        end
        sum_class_q <= class_d3;
    end

    assign o_sum_valid = sum_valid_q;
    assign o_sum_value = acc_q;
    assign o_sum_class = sum_class_q;

endmodule

//--- hdl/fc_argmax.sv
`timescale 1ns/1ps

module fc_argmax import fc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_start,
    input  logic                       i_sum_valid,
    input  logic signed [FC_ACC_W-1:0] i_sum_value,
    input  logic [FC_CLS_CNT_W-1:0]    i_sum_class,
    output logic [FC_CLS_W-1:0]        o_class,
    output logic signed [FC_ACC_W-1:0] o_score,
    output logic                       o_done
);

    logic                       seen_q;
    logic [FC_CLS_W-1:0]        best_class;
    logic signed [FC_ACC_W-1:0] best_score;
    logic                       done_q;
    logic                       take;

    // First sum always loads, later ones only if strictly larger
    assign take = i_sum_valid & (~seen_q | (i_sum_value > best_score));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_q     <= 1'b0;
            best_class <= '0;
            best_score <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= i_sum_valid && (i_sum_class == FC_CLS_CNT_W'(FC_NUM_CLASSES - 1));
            if (i_start) begin
                seen_q     <= 1'b0;
                best_class <= '0;
                best_score <= '0;
            end else if (take) begin
                seen_q     <= 1'b1;
                best_class <= FC_CLS_W'(i_sum_class);
                best_score <= i_sum_value;
            end
        end
    end

    assign o_class = best_class;
    assign o_score = best_score;
    assign o_done  = done_q;

endmodule

//--- hdl/fc_classifier.sv
`timescale 1ns/1ps

module fc_classifier import fc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // APB slave
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [FC_APB_AW-1:0]    i_paddr,
    input  logic [FC_APB_DW-1:0]    i_pwdata,
    output logic [FC_APB_DW-1:0]    o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    // Feature and weight memories
    output logic [FC_FM_ADDR_W-1:0] o_fm_addr,
    input  logic [FC_FM_DW-1:0]     i_fm_data,
    output logic [FC_W_ADDR_W-1:0]  o_w_addr,
    input  logic [FC_W_DW-1:0]      i_w_data,
    output logic                    o_done
);

    logic                       start_pulse;
    logic [FC_FM_BASE_W-1:0]    fm_base;
    logic [FC_W_BASE_W-1:0]     w_base;
    logic                       busy;

    logic                       issue_valid;
    logic                       row_first;
    logic                       row_last;
    logic [FC_CLS_CNT_W-1:0]    issue_class;

    logic                       sum_valid;
    logic signed [FC_ACC_W-1:0] sum_value;
    logic [FC_CLS_CNT_W-1:0]    sum_class;

    logic [FC_CLS_W-1:0]        result_class;
    logic signed [FC_ACC_W-1:0] result_score;
    logic                       result_done;

    ////////////////////
    // Register file
    fc_apb_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .i_busy      (busy),
        .i_res_done  (result_done),
        .i_res_class (result_class),
        .i_res_score (result_score),
        .o_start     (start_pulse),
        .o_fm_base   (fm_base),
        .o_w_base    (w_base)
    );

    ////////////////////
    // Address sequencer, datapath, argmax
    fc_addr_gen u_addr_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start       (start_pulse),
        .i_fm_base     (fm_base),
        .i_w_base      (w_base),
        .o_busy        (busy),
        .o_fm_addr     (o_fm_addr),
        .o_w_addr      (o_w_addr),
        .o_issue_valid (issue_valid),
        .o_row_first   (row_first),
        .o_row_last    (row_last),
        .o_issue_class (issue_class)
    );

    fc_mac8 u_mac (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_fm_data     (i_fm_data),
        .i_w_data      (i_w_data),
        .i_issue_valid (issue_valid),
        .i_row_first   (row_first),
        .i_row_last    (row_last),
        .i_issue_class (issue_class),
        .o_sum_valid   (sum_valid),
        .o_sum_value   (sum_value),
        .o_sum_class   (sum_class)
    );

    fc_argmax u_argmax (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_start     (start_pulse),
        .i_sum_valid (sum_valid),
        .i_sum_value (sum_value),
        .i_sum_class (sum_class),
        .o_class     (result_class),
        .o_score     (result_score),
        .o_done      (result_done)
    );

    assign o_done = result_done;

endmodule

//--- verif/fc_classifier_tb.sv
`timescale 1ns/1ps

module fc_classifier_tb import fc_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    localparam int NUM_RUNS     = 4;
    localparam int RUN_CYCLES   = 60;
    localparam int APB_CYCLES   = NUM_RUNS * (10 * 3 + 8) + 10 * 3;
    localparam int WATCHDOG_CYC = RESET_CYCLES + NUM_RUNS * RUN_CYCLES + APB_CYCLES;
    localparam int DONE_LATENCY = 45;
    localparam int NUM_ISSUES   = FC_NUM_CLASSES * FC_WORDS_PER_ROW;
    localparam int FM_WORDS     = 12;
    localparam int W_WORDS      = 40;
    localparam int STIM_WORDS   = FM_WORDS + W_WORDS + NUM_RUNS;
    localparam int FM_IMG_ADDR  = 'h40;
    localparam int W_IMG_ADDR   = 'h100;
    localparam logic [FC_APB_AW-1:0] REG_UNMAPPED = 8'h18;

    logic                    clk;
    logic                    rst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [FC_APB_AW-1:0]    paddr;
    logic [FC_APB_DW-1:0]    pwdata;
    logic [FC_APB_DW-1:0]    prdata;
    logic                    pready;
    logic                    pslverr;
    logic [FC_FM_ADDR_W-1:0] fm_addr;
    logic [FC_FM_DW-1:0]     fm_data;
    logic [FC_W_ADDR_W-1:0]  w_addr;
    logic [FC_W_DW-1:0]      w_data;
    logic                    done;

    logic [FC_FM_DW-1:0]     fm_mem [0:65535];
    logic [FC_W_DW-1:0]      w_mem [0:65535];
    logic [63:0]             stim [0:STIM_WORDS-1];
    logic [FC_FM_ADDR_W-1:0] fm_addr_q;
    logic [FC_W_ADDR_W-1:0]  w_addr_q;
    logic [FC_FM_ADDR_W-1:0] fm_seen [$];
    logic [FC_W_ADDR_W-1:0]  w_seen [$];
    int unsigned             lcg_state;

    fc_classifier u_fc_classifier (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr),
        .o_fm_addr (fm_addr),
        .i_fm_data (fm_data),
        .o_w_addr  (w_addr),
        .i_w_data  (w_data),
        .o_done    (done)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////
    // Memory models with one cycle of read latency
    always @(posedge clk) begin
        fm_addr_q <= fm_addr;
        w_addr_q  <= w_addr;
    end

    always @(negedge clk) begin
        fm_data <= fm_mem[fm_addr_q];
        w_data  <= w_mem[w_addr_q];
    end

    // Address log while the sequencer issues
    always @(negedge clk) begin
        if (u_fc_classifier.busy) begin
            fm_seen.push_back(fm_addr);
            w_seen.push_back(w_addr);
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic load_memories();
        for (int a = 0; a < 65536; a++) begin
            fm_mem[a] = {16'(a), ~16'(a), 16'(a) ^ 16'ha5a5, 16'(a) + 16'h1357};
            w_mem[a]  = {16'(a) ^ 16'h3c3c, 16'(a)};
        end
        $readmemh("verif/fc_stim.hex", stim);
        for (int i = 0; i < FM_WORDS; i++) begin
            fm_mem[FM_IMG_ADDR + i] = stim[i];
        end
        for (int i = 0; i < W_WORDS; i++) begin
            w_mem[W_IMG_ADDR + i] = stim[FM_WORDS + i][FC_W_DW-1:0];
        end
    endtask

    // Dot product of one class row with the feature image
    function automatic int class_sum(input logic [15:0] fm_base, input logic [15:0] w_base,
                                     input int cls);
        int                         sum;
        logic [FC_FM_DW-1:0]        fm_word;
        logic [FC_W_DW-1:0]         w_word;
        logic signed [FC_PIX_W-1:0] pix;
        logic signed [FC_WGT_W-1:0] wgt;
        sum = 0;
        for (int w = 0; w < FC_WORDS_PER_ROW; w++) begin
            fm_word = fm_mem[16'(fm_base + w)];
            w_word  = w_mem[16'(w_base + cls * FC_WORDS_PER_ROW + w)];
            for (int l = 0; l < FC_LANES; l++) begin
                pix = fm_word[l*FC_PIX_W +: FC_PIX_W];
                wgt = w_word[l*FC_WGT_W +: FC_WGT_W];
                sum = sum + pix * wgt;
            end
        end
        return sum;
    endfunction

    ////////////////////
    // APB transfers as a setup phase then an access phase
    task automatic write_reg(input logic [FC_APB_AW-1:0] addr, input logic [FC_APB_DW-1:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_reg(input logic [FC_APB_AW-1:0] addr, output logic [FC_APB_DW-1:0] data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        assert (pready == 1'b1) else
            report_failure($sformatf("mismatch o_pready at 0x%02h: got 0x%0h expected 0x1",
                                     addr, pready));
        data    = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input logic [FC_APB_AW-1:0] addr, input logic [FC_APB_DW-1:0] exp);
        logic [FC_APB_DW-1:0] data;
        logic                 err;
        read_reg(addr, data, err);
        assert (err == 1'b0) else
            report_failure($sformatf("mismatch o_pslverr at 0x%02h: got 0x%0h expected 0x0",
                                     addr, err));
        assert (data == exp) else
            report_failure($sformatf("mismatch o_prdata at 0x%02h: got 0x%08h expected 0x%08h",
                                     addr, data, exp));
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        report_failure("timeout waiting for done");
    end

    ////////////////////
    // Main sequence
    initial begin
        logic [63:0]             entry;
        logic [15:0]             fm_base;
        logic [15:0]             w_base;
        logic [15:0]             file_cls;
        logic [FC_APB_DW-1:0]    data;
        logic                    err;
        logic [FC_FM_ADDR_W-1:0] exp_fm;
        logic [FC_W_ADDR_W-1:0]  exp_w;
        int                      best_cls;
        int                      best_sum;
        int                      sum;
        int                      elapsed;
        int                      gap;

        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        fm_data   = '0;
        w_data    = '0;
        fm_addr_q = '0;
        w_addr_q  = '0;
        rst_n     = 1'b0;
        lcg_state = 73;
        load_memories();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Idle state after reset
        assert (done == 1'b0) else
            report_failure($sformatf("mismatch o_done after reset: got 0x%0h expected 0x0", done));
        check_reg(REG_STATUS, 32'h0);
        check_reg(REG_RES_CLASS, 32'h0);
        check_reg(REG_RES_SCORE, 32'h0);

        for (int r = 0; r < NUM_RUNS; r++) begin
            entry    = stim[FM_WORDS + W_WORDS + r];
            fm_base  = entry[47:32];
            w_base   = entry[31:16];
            file_cls = entry[15:0];

            // Argmax with the lower index kept on a tie
            best_cls = 0;
            best_sum = class_sum(fm_base, w_base, 0);
            for (int c = 1; c < FC_NUM_CLASSES; c++) begin
                sum = class_sum(fm_base, w_base, c);
                if (sum > best_sum) begin
                    best_cls = c;
                    best_sum = sum;
                end
            end
            assert (file_cls == 16'(best_cls)) else
                report_failure($sformatf("mismatch stim class: got 0x%0h expected 0x%0h",
                                         file_cls, best_cls));

            gap = 1 + int'(lcg_next() % 8);
            repeat (gap) @(negedge clk);
            // Done from the previous run is still held
            check_reg(REG_STATUS, (r > 0) ? 32'h2 : 32'h0);
            write_reg(REG_FM_BASE, 32'(fm_base));
            write_reg(REG_W_BASE, 32'(w_base));
            fm_seen.delete();
            w_seen.delete();

            // Returns in the cycle where the start pulse is high
            write_reg(REG_CTRL, 32'h1);
            check_reg(REG_STATUS, 32'h1);
            elapsed = 3;
            if (r == 1) begin
                write_reg(REG_CTRL, 32'h1);
                elapsed = elapsed + 3;
            end
            while (!done) begin
                @(negedge clk);
                elapsed++;
            end
            assert (elapsed == DONE_LATENCY) else
                report_failure($sformatf("mismatch o_done latency: got 0x%0h expected 0x%0h",
                                         elapsed, DONE_LATENCY));
            @(negedge clk);
            assert (done == 1'b0) else
                report_failure("o_done stayed high for more than one cycle");

            assert (fm_seen.size() == NUM_ISSUES) else
                report_failure($sformatf("mismatch o_fm_addr count: got 0x%0h expected 0x%0h",
                                         fm_seen.size(), NUM_ISSUES));
            for (int k = 0; k < NUM_ISSUES; k++) begin
                exp_fm = 16'(fm_base + k % FC_WORDS_PER_ROW);
                exp_w  = 16'(w_base + (k / FC_WORDS_PER_ROW) * FC_WORDS_PER_ROW
                             + k % FC_WORDS_PER_ROW);
                assert (fm_seen[k] == exp_fm) else
                    report_failure($sformatf("mismatch o_fm_addr: got 0x%04h expected 0x%04h",
                                             fm_seen[k], exp_fm));
                assert (w_seen[k] == exp_w) else
                    report_failure($sformatf("mismatch o_w_addr: got 0x%04h expected 0x%04h",
                                             w_seen[k], exp_w));
            end

            check_reg(REG_RES_CLASS, 32'(best_cls));
            check_reg(REG_RES_SCORE, 32'(best_sum));
            check_reg(REG_STATUS, 32'h2);
        end

        // Unmapped offset
        read_reg(REG_UNMAPPED, data, err);
        assert (err == 1'b1) else
            report_failure("no slave error on a read of an unmapped address");
        assert (data == '0) else
            report_failure($sformatf("mismatch o_prdata at 0x%02h: got 0x%08h expected 0x0",
                                     REG_UNMAPPED, data));
        check_reg(REG_STATUS, 32'h2);

        $display("test passed");
        $finish;
    end

endmodule

//--- src.f
hdl/fc_pkg.sv
hdl/fc_apb_regs.sv
hdl/fc_addr_gen.sv
hdl/fc_mac8.sv
hdl/fc_argmax.sv
hdl/fc_classifier.sv
verif/fc_classifier_tb.sv

//--- Bender.yml
package:
  name: fc_classifier

sources:
  - files:
      - hdl/fc_pkg.sv
      - hdl/fc_apb_regs.sv
      - hdl/fc_addr_gen.sv
      - hdl/fc_mac8.sv
      - hdl/fc_argmax.sv
      - hdl/fc_classifier.sv
  - target: test
    files:
      - verif/fc_classifier_tb.sv

//--- verif/fc_stim.hex
// Feature words (64 bit, lane 0 in the low byte), weight words (32 bit, lane 0 in the low nibble)
// Run lines: feature base, weight base, expected class as three 4-digit hex fields
// Image A at feature address 0x40, pixels 1 2 3 4
0101010101010101
0202020202020202
0303030303030303
0404040404040404
// Image B at 0x44, pixels 4 3 2 1
0404040404040404
0303030303030303
0202020202020202
0101010101010101
// Image C at 0x48, all pixels -1
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
// Weight image at 0x100, four words per class
// Class 0
11111111
11111111
11111111
11111111
// Class 1
77777777
00000000
00000000
FFFFFFFF
// Class 2
00000000
00000000
00000000
77777777
// Class 3
FFFFFFFF
FFFFFFFF
FFFFFFFF
FFFFFFFF
// Class 4
22222222
22222222
22222222
22222222
// Class 5, same row as class 2
00000000
00000000
00000000
77777777
// Class 6
33333333
00000000
00000000
00000000
// Class 7
88888888
00000000
00000000
77777777
// Class 8
00000000
55555555
00000000
00000000
// Class 9
11111111
00000000
11111111
00000000
// Runs, the first ties classes 2 and 5
004001000002
004401000001
004801000003
004201000004
